// File: exec_unit.f
+incdir+source
source/isa_pkg.sv
source/apb_map_pkg.sv
source/alu.sv
source/instr_decoder.sv
source/register_file.sv
source/exec_apb_port.sv
source/exec_unit.sv
testbench/exec_unit_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds and runs the exec_unit testbench with Verilator
set -u

TOP=exec_unit_tb
LOG=sim.log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module "$TOP" -f exec_unit.f -o "$TOP"
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q '\*\*\* TEST PASSED \*\*\*' "$LOG"; then
    echo "simulation passed"
    exit 0
fi
echo "simulation failed"
exit 1

// File: source/alu.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module alu (
    input  isa_pkg::opcode_e          opcode,
    input  isa_pkg::sub_base_e        sub_op_base,
    input  isa_pkg::sub_ls_e          sub_op_ls,
    input  logic [`DATA_WIDTH-1:0]    src1,
    input  logic [`DATA_WIDTH-1:0]    src2,
    output logic [`DATA_WIDTH-1:0]    alu_result,
    output logic                      alu_overflow,
    output logic                      alu_zero
);
    import isa_pkg::*;

    localparam int SHAMT_WIDTH = $clog2(`DATA_WIDTH);

    logic [SHAMT_WIDTH-1:0]     shamt;
    logic [2*`DATA_WIDTH-1:0]   rotate;
    logic [`DATA_WIDTH:0]       add_out;
    logic [`DATA_WIDTH:0]       sub_out;

    // returns {overflow, sum}
    function automatic logic [`DATA_WIDTH:0] add_ovf(
        input logic [`DATA_WIDTH-1:0] a,
        input logic [`DATA_WIDTH-1:0] b,
        input logic                   carry_in
    );
        logic [`DATA_WIDTH-2:0] low;
        logic                   c_sign;
        logic                   c_out;
        logic                   msb;
        {c_sign, low} = a[`DATA_WIDTH-2:0] + b[`DATA_WIDTH-2:0] + carry_in;
        {c_out, msb} = a[`DATA_WIDTH-1] + b[`DATA_WIDTH-1] + c_sign;
        // carry into sign differs from carry out
        return {c_sign ^ c_out, msb, low};
    endfunction

    assign add_out = add_ovf(src1, src2, 1'b0);
    // subtract as a + ~b + 1
    assign sub_out = add_ovf(src1, ~src2, 1'b1);

    assign shamt  = src2[SHAMT_WIDTH-1:0];
    assign rotate = {src1, src1} >> shamt;

    always_comb
    begin
        alu_result   = '0;
        alu_overflow = 1'b0;
        case (opcode)
            TY_BASE:
            begin
                case (sub_op_base)
                    ADD:     {alu_overflow, alu_result} = add_out;
                    SUB:     {alu_overflow, alu_result} = sub_out;
                    AND:     alu_result = src1 & src2;
                    OR:      alu_result = src1 | src2;
                    XOR:     alu_result = src1 ^ src2;
                    SRLI:    alu_result = src1 >> shamt;
                    SLLI:    alu_result = src1 << shamt;
                    ROTRI:   alu_result = rotate[`DATA_WIDTH-1:0];
                    default: alu_result = '0;
                endcase
            end
            // address adds share the ADDI path
            ADDI, LWI, SWI: {alu_overflow, alu_result} = add_out;
            ORI:            alu_result = src1 | src2;
            XORI:           alu_result = src1 ^ src2;
            MOVI:           alu_result = src2;
            TY_LS:
            begin
                case (sub_op_ls)
                    LW, SW:  {alu_overflow, alu_result} = add_out;
                    default: alu_result = '0;
                endcase
            end
            // branch compare
            TY_B:           alu_result = src1 ^ src2;
            default:        alu_result = '0;
        endcase
    end

    assign alu_zero = (alu_result == '0);

endmodule

// File: source/apb_map_pkg.sv
`include "exec_params.svh"

package apb_map_pkg;

    // byte offsets in the APB window
    typedef enum logic [`APB_ADDR_WIDTH-1:0] {
        INSTR    = 'h00,
        RESULT   = 'h04,
        STATUS   = 'h08,
        // GPR n lives at GPR_BASE + 4n
        GPR_BASE = 'h80
    } reg_offset_e;

    // status register bits
    localparam int STATUS_ZERO_BIT = 0;
    localparam int STATUS_OVF_BIT  = 1;

endpackage

// File: source/exec_apb_port.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module exec_apb_port (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [`DATA_WIDTH-1:0]      pwdata,
    output logic [`DATA_WIDTH-1:0]      prdata,
    output logic                        pready,
    output logic                        pslverr,
    output isa_pkg::instr_word_t        instr,
    output logic                        issue,
    input  logic                        wb_en,
    input  logic [`DATA_WIDTH-1:0]      alu_result,
    input  logic                        alu_overflow,
    input  logic                        alu_zero,
    input  logic [`DATA_WIDTH-1:0]      host_rd_data,
    output logic                        reg_we,
    output logic [`REG_IDX_WIDTH-1:0]   reg_wr_idx,
    output logic [`DATA_WIDTH-1:0]      reg_wr_data,
    output logic [`REG_IDX_WIDTH-1:0]   host_rd_idx,
    output logic                        host_rd_sel,
    input  logic [`REG_IDX_WIDTH-1:0]   rt_idx
);
    import apb_map_pkg::*;

    logic                        access;
    logic                        is_instr;
    logic                        is_result;
    logic                        is_status;
    logic                        is_gpr;
    logic                        mapped;
    logic [`APB_ADDR_WIDTH-1:0]  gpr_off;
    logic [`REG_IDX_WIDTH-1:0]   gpr_idx;
    logic                        host_we;
    logic                        issue_req;
    logic [`DATA_WIDTH-1:0]      result_q;
    logic                        zero_q;
    logic                        ovf_q;
    logic [`DATA_WIDTH-1:0]      status_word;

    // no wait states
    assign pready = 1'b1;
    assign access = psel & penable;

    assign is_instr  = (paddr == INSTR);
    assign is_result = (paddr == RESULT);
    assign is_status = (paddr == STATUS);
    assign gpr_off   = paddr - GPR_BASE;
    assign is_gpr    = (paddr >= GPR_BASE) && (gpr_off[1:0] == 2'b00)
                       && (gpr_off[`APB_ADDR_WIDTH-1:2] < `REG_COUNT);
    assign gpr_idx   = gpr_off[`REG_IDX_WIDTH+1:2];
    assign mapped    = is_instr | is_result | is_status | is_gpr;

    assign pslverr   = access & (~mapped | (pwrite & (is_result | is_status)));
    assign issue_req = access & pwrite & is_instr;
    assign host_we   = access & pwrite & is_gpr;

    // port A belongs to the host only in a GPR read access
    assign host_rd_sel = access & ~pwrite & is_gpr;
    assign host_rd_idx = gpr_idx;

    // issue never lands in an access cycle, so no write collision
    assign reg_we      = host_we | (issue & wb_en);
    assign reg_wr_idx  = issue ? rt_idx : gpr_idx;
    assign reg_wr_data = issue ? alu_result : pwdata;

    always_comb
    begin
        status_word                  = '0;
        status_word[STATUS_ZERO_BIT] = zero_q;
        status_word[STATUS_OVF_BIT]  = ovf_q;
    end

    always_comb
    begin
        if (is_instr)
            prdata = instr;
        else if (is_result)
            prdata = result_q;
        else if (is_status)
            prdata = status_word;
        else if (is_gpr)
            prdata = host_rd_data;
        else
            prdata = '0;
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            instr    <= '0;
            issue    <= 1'b0;
            result_q <= '0;
            zero_q   <= 1'b0;
            ovf_q    <= 1'b0;
        end
        else
        begin
            issue <= issue_req;
            if (issue_req)
                instr <= pwdata;
            // capture flags while the issued word is decoded
            if (issue)
            begin
                result_q <= alu_result;
                zero_q   <= alu_zero;
                ovf_q    <= alu_overflow;
            end
        end
    end

endmodule

// File: source/exec_params.svh
`ifndef EXEC_PARAMS_SVH
`define EXEC_PARAMS_SVH

// datapath and register file sizing
`define DATA_WIDTH     32
`define REG_COUNT      32
`define REG_IDX_WIDTH  5

// byte address space seen over APB
`define APB_ADDR_WIDTH 8

`endif

// File: source/exec_unit.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module exec_unit (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`APB_ADDR_WIDTH-1:0]  paddr,
    input  logic [`DATA_WIDTH-1:0]      pwdata,
    output logic [`DATA_WIDTH-1:0]      prdata,
    output logic                        pready,
    output logic                        pslverr
);
    import isa_pkg::*;

    instr_word_t                 instr;
    opcode_e                     opcode;
    sub_base_e                   sub_op_base;
    sub_ls_e                     sub_op_ls;
    logic                        issue;
    logic                        wb_en;
    logic                        use_imm;
    logic [`DATA_WIDTH-1:0]      imm_value;
    logic [`REG_IDX_WIDTH-1:0]   ra_idx;
    logic [`REG_IDX_WIDTH-1:0]   rb_idx;
    logic [`REG_IDX_WIDTH-1:0]   rt_idx;
    logic [`REG_IDX_WIDTH-1:0]   host_rd_idx;
    logic                        host_rd_sel;
    logic [`REG_IDX_WIDTH-1:0]   port_a_idx;
    logic [`DATA_WIDTH-1:0]      rs1_data;
    logic [`DATA_WIDTH-1:0]      rs2_data;
    logic [`DATA_WIDTH-1:0]      src2;
    logic [`DATA_WIDTH-1:0]      alu_result;
    logic                        alu_overflow;
    logic                        alu_zero;
    logic                        reg_we;
    logic [`REG_IDX_WIDTH-1:0]   reg_wr_idx;
    logic [`DATA_WIDTH-1:0]      reg_wr_data;

    // host borrows port A during GPR reads
    assign port_a_idx = host_rd_sel ? host_rd_idx : ra_idx;
    assign src2       = use_imm ? imm_value : rs2_data;

    exec_apb_port apb_port_i (
        .clk          (clk),
        .reset        (reset),
        .psel         (psel),
        .penable      (penable),
        .pwrite       (pwrite),
        .paddr        (paddr),
        .pwdata       (pwdata),
        .prdata       (prdata),
        .pready       (pready),
        .pslverr      (pslverr),
        .instr        (instr),
        .issue        (issue),
        .wb_en        (wb_en),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow),
        .alu_zero     (alu_zero),
        .host_rd_data (rs1_data),
        .reg_we       (reg_we),
        .reg_wr_idx   (reg_wr_idx),
        .reg_wr_data  (reg_wr_data),
        .host_rd_idx  (host_rd_idx),
        .host_rd_sel  (host_rd_sel),
        .rt_idx       (rt_idx)
    );

    instr_decoder decoder_i (
        .instr       (instr),
        .ra_idx      (ra_idx),
        .rb_idx      (rb_idx),
        .rt_idx      (rt_idx),
        .imm_value   (imm_value),
        .use_imm     (use_imm),
        .wb_en       (wb_en),
        .opcode      (opcode),
        .sub_op_base (sub_op_base),
        .sub_op_ls   (sub_op_ls)
    );

    register_file regfile_i (
        .clk       (clk),
        .reset     (reset),
        .rd_a_idx  (port_a_idx),
        .rd_a_data (rs1_data),
        .rd_b_idx  (rb_idx),
        .rd_b_data (rs2_data),
        .we        (reg_we),
        .wr_idx    (reg_wr_idx),
        .wr_data   (reg_wr_data)
    );

    alu alu_i (
        .opcode       (opcode),
        .sub_op_base  (sub_op_base),
        .sub_op_ls    (sub_op_ls),
        .src1         (rs1_data),
        .src2         (src2),
        .alu_result   (alu_result),
        .alu_overflow (alu_overflow),
        .alu_zero     (alu_zero)
    );

endmodule

// File: source/instr_decoder.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module instr_decoder (
    input  isa_pkg::instr_word_t         instr,
    output logic [`REG_IDX_WIDTH-1:0]    ra_idx,
    output logic [`REG_IDX_WIDTH-1:0]    rb_idx,
    output logic [`REG_IDX_WIDTH-1:0]    rt_idx,
    output logic [`DATA_WIDTH-1:0]       imm_value,
    output logic                         use_imm,
    output logic                         wb_en,
    output isa_pkg::opcode_e             opcode,
    output isa_pkg::sub_base_e           sub_op_base,
    output isa_pkg::sub_ls_e             sub_op_ls
);
    import isa_pkg::*;

    logic [`DATA_WIDTH-1:0] imm15_sext;
    logic [`DATA_WIDTH-1:0] imm15_zext;
    logic [`DATA_WIDTH-1:0] imm20_sext;
    logic [`DATA_WIDTH-1:0] shamt_zext;

    assign opcode      = instr.rtype.opcode;
    assign rt_idx      = instr.rtype.rt;
    assign sub_op_ls   = sub_ls_e'(instr.rtype.sub_ls);
    assign sub_op_base = sub_base_e'(instr.rtype.sub_ls[4:0]);

    assign imm15_sext = {{(`DATA_WIDTH-15){instr.itype.imm15[14]}}, instr.itype.imm15};
    assign imm15_zext = {{(`DATA_WIDTH-15){1'b0}}, instr.itype.imm15};
    assign imm20_sext = {{(`DATA_WIDTH-20){instr.mtype.imm20[19]}}, instr.mtype.imm20};
    // shift amount comes from the rb field
    assign shamt_zext = {{(`DATA_WIDTH-`REG_IDX_WIDTH){1'b0}}, instr.rtype.rb};

    always_comb
    begin
        ra_idx    = instr.rtype.ra;
        rb_idx    = instr.rtype.rb;
        imm_value = '0;
        use_imm   = 1'b0;
        wb_en     = 1'b0;
        case (opcode)
            TY_BASE:
            begin
                case (sub_op_base)
                    ADD, SUB, AND, OR, XOR: wb_en = 1'b1;
                    SRLI, SLLI, ROTRI:
                    begin
                        imm_value = shamt_zext;
                        use_imm   = 1'b1;
                        wb_en     = 1'b1;
                    end
                    default: wb_en = 1'b0;
                endcase
            end
            ADDI:
            begin
                imm_value = imm15_sext;
                use_imm   = 1'b1;
                wb_en     = 1'b1;
            end
            ORI, XORI:
            begin
                imm_value = imm15_zext;
                use_imm   = 1'b1;
                wb_en     = 1'b1;
            end
            MOVI:
            begin
                imm_value = imm20_sext;
                use_imm   = 1'b1;
                wb_en     = 1'b1;
            end
            // address only, nothing written back
            LWI, SWI:
            begin
                imm_value = imm15_sext;
                use_imm   = 1'b1;
            end
            TY_B:
            begin
                // compare rt against ra
                ra_idx = instr.rtype.rt;
                rb_idx = instr.rtype.ra;
            end
            default: wb_en = 1'b0;
        endcase
    end

endmodule

// File: source/isa_pkg.sv
`include "exec_params.svh"

package isa_pkg;

    // major opcodes, bits 31:26
    typedef enum logic [5:0] {
        LWI     = 6'b000100,
        SWI     = 6'b010100,
        TY_LS   = 6'b011100,
        TY_BASE = 6'b100000,
        MOVI    = 6'b100010,
        JJ      = 6'b100100,
        TY_B    = 6'b100110,
        ADDI    = 6'b101000,
        XORI    = 6'b101011,
        ORI     = 6'b101100
    } opcode_e;

    typedef enum logic [4:0] {
        ADD   = 5'b00000,
        SUB   = 5'b00001,
        AND   = 5'b00010,
        XOR   = 5'b00011,
        OR    = 5'b00100,
        SLLI  = 5'b01000,
        SRLI  = 5'b01001,
        ROTRI = 5'b01011
    } sub_base_e;

    typedef enum logic [7:0] {
        LW = 8'b0000_0010,
        SW = 8'b0000_1010
    } sub_ls_e;

    // register form, base sub-opcode is sub_ls[4:0]
    typedef struct packed {
        opcode_e                   opcode;
        logic [`REG_IDX_WIDTH-1:0] rt;
        logic [`REG_IDX_WIDTH-1:0] ra;
        logic [`REG_IDX_WIDTH-1:0] rb;
        logic [2:0]                rsvd;
        logic [7:0]                sub_ls;
    } instr_reg_t;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`REG_IDX_WIDTH-1:0] rt;
        logic [`REG_IDX_WIDTH-1:0] ra;
        logic                      rsvd;
        logic [14:0]               imm15;
    } instr_imm_t;

    typedef struct packed {
        opcode_e                   opcode;
        logic [`REG_IDX_WIDTH-1:0] rt;
        logic                      rsvd;
        logic [19:0]               imm20;
    } instr_mov_t;

    typedef union packed {
        instr_reg_t rtype;
        instr_imm_t itype;
        instr_mov_t mtype;
    } instr_word_t;

endpackage

// File: source/register_file.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module register_file (
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`REG_IDX_WIDTH-1:0]   rd_a_idx,
    output logic [`DATA_WIDTH-1:0]      rd_a_data,
    input  logic [`REG_IDX_WIDTH-1:0]   rd_b_idx,
    output logic [`DATA_WIDTH-1:0]      rd_b_data,
    input  logic                        we,
    input  logic [`REG_IDX_WIDTH-1:0]   wr_idx,
    input  logic [`DATA_WIDTH-1:0]      wr_data
);

    logic [`DATA_WIDTH-1:0] regs [`REG_COUNT];

    // r0 is an ordinary register here
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (we)
        begin
            regs[wr_idx] <= wr_data;
        end
    end

    // asynchronous read ports
    assign rd_a_data = regs[rd_a_idx];
    assign rd_b_data = regs[rd_b_idx];

endmodule

// File: testbench/exec_unit_tb.sv
`timescale 1ns/100ps
`include "exec_params.svh"

module exec_unit_tb;
    import isa_pkg::*;
    import apb_map_pkg::*;

    localparam int HALF_PERIOD  = 10;
    localparam int RESET_CYCLES = 10;
    localparam int SEED         = 94025;
    localparam int NUM_TESTS    = 27;
    localparam int MSB          = `DATA_WIDTH - 1;
    // 40 cycles per table entry, plus reset and the APB-only checks
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_TESTS * 40 + (`REG_COUNT + 16) * 4;

    localparam logic [`REG_IDX_WIDTH-1:0] RA_IDX = 5;
    localparam logic [`REG_IDX_WIDTH-1:0] RB_IDX = 9;
    localparam logic [`REG_IDX_WIDTH-1:0] RT_IDX = 17;

    typedef struct {
        string                  name;
        instr_word_t            instr;
        logic [`DATA_WIDTH-1:0] va;
        logic [`DATA_WIDTH-1:0] vb;
        logic [`DATA_WIDTH-1:0] vt;
        logic [`DATA_WIDTH-1:0] exp_res;
        logic                   exp_zero;
        logic                   exp_ovf;
        logic                   exp_wb;
    } test_t;

    logic                       clk;
    logic                       reset;
    logic                       psel;
    logic                       penable;
    logic                       pwrite;
    logic [`APB_ADDR_WIDTH-1:0] paddr;
    logic [`DATA_WIDTH-1:0]     pwdata;
    logic [`DATA_WIDTH-1:0]     prdata;
    logic                       pready;
    logic                       pslverr;

    test_t tests [NUM_TESTS];
    int    n_tests;
    int    pass_count;
    int    fail_count;
    int    test_errors;
    string cur_test;

    exec_unit dut_i (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("*** TEST FAILED ***");
        $finish;
    end

    function automatic logic [`APB_ADDR_WIDTH-1:0] gpr_addr(input int n);
        logic [`APB_ADDR_WIDTH-1:0] addr;
        addr = GPR_BASE;
        return addr + `APB_ADDR_WIDTH'(4 * n);
    endfunction

    function automatic instr_word_t enc_reg(
        input opcode_e                   op,
        input logic [7:0]                sub,
        input logic [`REG_IDX_WIDTH-1:0] rb
    );
        instr_word_t w;
        w              = '0;
        w.rtype.opcode = op;
        w.rtype.rt     = RT_IDX;
        w.rtype.ra     = RA_IDX;
        w.rtype.rb     = rb;
        w.rtype.sub_ls = sub;
        return w;
    endfunction

    function automatic instr_word_t enc_base(
        input sub_base_e                 sub,
        input logic [`REG_IDX_WIDTH-1:0] rb
    );
        return enc_reg(TY_BASE, {3'b000, sub}, rb);
    endfunction

    function automatic instr_word_t enc_imm(input opcode_e op, input logic [14:0] imm);
        instr_word_t w;
        w              = '0;
        w.itype.opcode = op;
        w.itype.rt     = RT_IDX;
        w.itype.ra     = RA_IDX;
        w.itype.imm15  = imm;
        return w;
    endfunction

    function automatic instr_word_t enc_movi(input logic [19:0] imm);
        instr_word_t w;
        w              = '0;
        w.mtype.opcode = MOVI;
        w.mtype.rt     = RT_IDX;
        w.mtype.imm20  = imm;
        return w;
    endfunction

    function automatic void add_signed(
        input  logic [`DATA_WIDTH-1:0] a,
        input  logic [`DATA_WIDTH-1:0] b,
        output logic [`DATA_WIDTH-1:0] sum,
        output logic                   ovf
    );
        sum = a + b;
        // same-sign operands with a sum of the other sign
        ovf = (a[MSB] == b[MSB]) && (sum[MSB] != a[MSB]);
    endfunction

    // reference behaviour of one instruction
    function automatic void model_exec(
        input  instr_word_t            w,
        input  logic [`DATA_WIDTH-1:0] va,
        input  logic [`DATA_WIDTH-1:0] vb,
        input  logic [`DATA_WIDTH-1:0] vt,
        output logic [`DATA_WIDTH-1:0] res,
        output logic                   ovf,
        output logic                   wb
    );
        logic [`DATA_WIDTH-1:0] s15;
        logic [`DATA_WIDTH-1:0] z15;
        logic [`DATA_WIDTH-1:0] s20;
        logic [4:0]             sh;
        s15 = {{(`DATA_WIDTH-15){w.itype.imm15[14]}}, w.itype.imm15};
        z15 = {{(`DATA_WIDTH-15){1'b0}}, w.itype.imm15};
        s20 = {{(`DATA_WIDTH-20){w.mtype.imm20[19]}}, w.mtype.imm20};
        sh  = w.rtype.rb;
        res = '0;
        ovf = 1'b0;
        wb  = 1'b0;
        case (w.rtype.opcode)
            TY_BASE:
            begin
                wb = 1'b1;
                case (w.rtype.sub_ls[4:0])
                    ADD:     add_signed(va, vb, res, ovf);
                    SUB:
                    begin
                        res = va - vb;
                        ovf = (va[MSB] != vb[MSB]) && (res[MSB] != va[MSB]);
                    end
                    AND:     res = va & vb;
                    OR:      res = va | vb;
                    XOR:     res = va ^ vb;
                    SRLI:    res = va >> sh;
                    SLLI:    res = va << sh;
                    ROTRI:   res = (va >> sh) | (va << (`DATA_WIDTH - sh));
                    default: wb = 1'b0;
                endcase
            end
            ADDI:
            begin
                add_signed(va, s15, res, ovf);
                wb = 1'b1;
            end
            ORI:
            begin
                res = va | z15;
                wb  = 1'b1;
            end
            XORI:
            begin
                res = va ^ z15;
                wb  = 1'b1;
            end
            MOVI:
            begin
                res = s20;
                wb  = 1'b1;
            end
            LWI, SWI: add_signed(va, s15, res, ovf);
            TY_LS:
            begin
                if (w.rtype.sub_ls == LW || w.rtype.sub_ls == SW)
                    add_signed(va, vb, res, ovf);
            end
            TY_B:     res = vt ^ va;
            default:  res = '0;
        endcase
    endfunction

    function automatic void add_test(
        input string                  name,
        input instr_word_t            w,
        input logic [`DATA_WIDTH-1:0] va,
        input logic [`DATA_WIDTH-1:0] vb,
        input logic [`DATA_WIDTH-1:0] vt
    );
        test_t                  t;
        logic [`DATA_WIDTH-1:0] res;
        logic                   ovf;
        logic                   wb;
        model_exec(w, va, vb, vt, res, ovf, wb);
        t.name     = name;
        t.instr    = w;
        t.va       = va;
        t.vb       = vb;
        t.vt       = vt;
        t.exp_res  = res;
        t.exp_zero = (res == '0);
        t.exp_ovf  = ovf;
        t.exp_wb   = wb;
        tests[n_tests] = t;
        n_tests++;
    endfunction

    function automatic void build_table();
        logic [`DATA_WIDTH-1:0] same;
        same    = $urandom();
        n_tests = 0;
        add_test("add_rand",   enc_base(ADD, RB_IDX),   $urandom(), $urandom(), $urandom());
        add_test("add_ovf",    enc_base(ADD, RB_IDX),   32'h7fff_ffff, 32'h1, $urandom());
        add_test("sub_rand",   enc_base(SUB, RB_IDX),   $urandom(), $urandom(), $urandom());
        add_test("sub_ovf",    enc_base(SUB, RB_IDX),   32'h8000_0000, 32'h1, $urandom());
        add_test("sub_zero",   enc_base(SUB, RB_IDX),   same, same, $urandom());
        add_test("and_rand",   enc_base(AND, RB_IDX),   $urandom(), $urandom(), $urandom());
        add_test("or_rand",    enc_base(OR, RB_IDX),    $urandom(), $urandom(), $urandom());
        add_test("xor_rand",   enc_base(XOR, RB_IDX),   $urandom(), $urandom(), $urandom());
        // rb field is the shift amount here
        add_test("srli_0",     enc_base(SRLI, 0),       $urandom(), $urandom(), $urandom());
        add_test("srli_31",    enc_base(SRLI, 31),      32'hf000_0001, $urandom(), $urandom());
        add_test("slli_31",    enc_base(SLLI, 31),      $urandom(), $urandom(), $urandom());
        add_test("slli_7",     enc_base(SLLI, 7),       $urandom(), $urandom(), $urandom());
        add_test("rotri_0",    enc_base(ROTRI, 0),      $urandom(), $urandom(), $urandom());
        add_test("rotri_31",   enc_base(ROTRI, 31),     $urandom(), $urandom(), $urandom());
        add_test("rotri_13",   enc_base(ROTRI, 13),     $urandom(), $urandom(), $urandom());
        add_test("base_undef", enc_base(sub_base_e'(5'b11111), RB_IDX),
                 $urandom(), $urandom(), $urandom());
        add_test("addi_neg",   enc_imm(ADDI, 15'h7ff0), $urandom(), $urandom(), $urandom());
        add_test("ori_top",    enc_imm(ORI, 15'h4abc),  $urandom(), $urandom(), $urandom());
        add_test("xori_top",   enc_imm(XORI, 15'h7fff), $urandom(), $urandom(), $urandom());
        add_test("movi_neg",   enc_movi(20'h80123),     $urandom(), $urandom(), $urandom());
        add_test("lwi",        enc_imm(LWI, 15'h0040),  $urandom(), $urandom(), $urandom());
        add_test("swi",        enc_imm(SWI, 15'h7ffc),  $urandom(), $urandom(), $urandom());
        add_test("lw",         enc_reg(TY_LS, LW, RB_IDX), $urandom(), $urandom(), $urandom());
        add_test("sw",         enc_reg(TY_LS, SW, RB_IDX), $urandom(), $urandom(), $urandom());
        add_test("tyb_diff",   enc_reg(TY_B, 8'h00, RB_IDX), $urandom(), $urandom(), $urandom());
        add_test("tyb_equal",  enc_reg(TY_B, 8'h00, RB_IDX), same, $urandom(), same);
        add_test("jj",         enc_imm(JJ, 15'h1234),   $urandom(), $urandom(), $urandom());
    endfunction

    task automatic apb_write(
        input  logic [`APB_ADDR_WIDTH-1:0] addr,
        input  logic [`DATA_WIDTH-1:0]     data,
        output logic                       err
    );
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b1;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        err = pslverr;
        check_value("pready", 1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic apb_read(
        input  logic [`APB_ADDR_WIDTH-1:0] addr,
        output logic [`DATA_WIDTH-1:0]     data,
        output logic                       err
    );
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= addr;
        @(posedge clk);
        penable <= 1'b1;
        // read data is valid mid access phase
        @(negedge clk);
        data = prdata;
        err  = pslverr;
        check_value("pready", 1, pready);
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    function automatic void begin_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endfunction

    function automatic void check_value(
        input string                  field,
        input logic [`DATA_WIDTH-1:0] expected,
        input logic [`DATA_WIDTH-1:0] actual
    );
        if (actual !== expected)
        begin
            $display("ERROR %s %s: expected %h, actual %h", cur_test, field, expected, actual);
            test_errors++;
        end
    endfunction

    function automatic void end_test();
        if (test_errors == 0)
        begin
            pass_count++;
            $display("test %s: ok", cur_test);
        end
        else
        begin
            fail_count++;
            $display("test %s: %0d mismatches", cur_test, test_errors);
        end
    endfunction

    task automatic check_reset_values();
        logic [`DATA_WIDTH-1:0] data;
        logic                   err;
        begin_test("reset_reads");
        apb_read(INSTR, data, err);
        check_value("INSTR", '0, data);
        apb_read(RESULT, data, err);
        check_value("RESULT", '0, data);
        apb_read(STATUS, data, err);
        check_value("STATUS", '0, data);
        for (int n = 0; n < `REG_COUNT; n++)
        begin
            apb_read(gpr_addr(n), data, err);
            check_value($sformatf("GPR%0d", n), '0, data);
            check_value("pslverr", '0, err);
        end
        end_test();
    endtask

    task automatic check_slave_errors();
        logic [`DATA_WIDTH-1:0] data;
        logic                   err;
        begin_test("slave_errors");
        apb_read(8'h0c, data, err);
        check_value("pslverr 0x0c", 1, err);
        apb_read(8'h7c, data, err);
        check_value("pslverr 0x7c", 1, err);
        apb_write(RESULT, 32'hdead_beef, err);
        check_value("pslverr RESULT write", 1, err);
        apb_write(STATUS, 32'h3, err);
        check_value("pslverr STATUS write", 1, err);
        // refused writes leave RESULT alone
        apb_read(RESULT, data, err);
        check_value("RESULT", '0, data);
        check_value("pslverr RESULT read", '0, err);
        end_test();
    endtask

    task automatic check_gpr_readback();
        logic [`DATA_WIDTH-1:0] value;
        logic [`DATA_WIDTH-1:0] data;
        logic                   err;
        begin_test("gpr_readback");
        for (int n = 0; n < `REG_COUNT; n++)
        begin
            if (n == 0 || n == `REG_COUNT - 1)
            begin
                value = $urandom();
                apb_write(gpr_addr(n), value, err);
                check_value("pslverr write", '0, err);
                apb_read(gpr_addr(n), data, err);
                check_value($sformatf("GPR%0d", n), value, data);
            end
        end
        end_test();
    endtask

    task automatic run_entry(input int i);
        logic [`DATA_WIDTH-1:0] data;
        logic [`DATA_WIDTH-1:0] status_exp;
        logic                   err;
        logic                   err_any;
        begin_test(tests[i].name);
        apb_write(gpr_addr(RA_IDX), tests[i].va, err);
        err_any = err;
        apb_write(gpr_addr(RB_IDX), tests[i].vb, err);
        err_any |= err;
        apb_write(gpr_addr(RT_IDX), tests[i].vt, err);
        err_any |= err;
        apb_write(INSTR, tests[i].instr, err);
        err_any |= err;
        apb_read(RESULT, data, err);
        err_any |= err;
        check_value("RESULT", tests[i].exp_res, data);
        status_exp                  = '0;
        status_exp[STATUS_ZERO_BIT] = tests[i].exp_zero;
        status_exp[STATUS_OVF_BIT]  = tests[i].exp_ovf;
        apb_read(STATUS, data, err);
        err_any |= err;
        check_value("STATUS", status_exp, data);
        apb_read(gpr_addr(RT_IDX), data, err);
        err_any |= err;
        check_value("GPR rt", tests[i].exp_wb ? tests[i].exp_res : tests[i].vt, data);
        check_value("pslverr", '0, err_any);
        end_test();
    endtask

    initial
    begin
        void'($urandom(SEED));
        pass_count  = 0;
        fail_count  = 0;
        test_errors = 0;
        reset   <= 1'b1;
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        paddr   <= '0;
        pwdata  <= '0;
        build_table();
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        check_reset_values();
        check_slave_errors();
        check_gpr_readback();
        for (int i = 0; i < n_tests; i++)
            run_entry(i);
        $display("summary: %0d tests, %0d passed, %0d failed",
                 pass_count + fail_count, pass_count, fail_count);
        if (fail_count == 0)
            $display("*** TEST PASSED ***");
        else
            $display("*** TEST FAILED ***");
        $finish;
    end

endmodule
